//--- hd44780_defines.svh
// build-wide constants for the lcd bring-up harness
// delays are in clock ticks and must fit in H4_TIMER_BITS
// blink width is sized for simulation, widen it for hardware (about 25 at 6 MHz)
// synchronizer depth must be 2 or more
`ifndef HD44780_DEFINES_SVH
`define HD44780_DEFINES_SVH

// ************************************************************************
// state timer
// ************************************************************************
`define H4_TIMER_BITS   8       // must hold the longest delay (114)

// three test delays run by the exerciser, in order
`define H4_DELAY_A      114
`define H4_DELAY_B      1
`define H4_DELAY_C      0       // zero delay, end strobe right after load

// ************************************************************************
// alive leds and button
// ************************************************************************
`define H4_BLINK_BITS   8       // free-running blink counter width, needs >= 4
`define H4_PWM_BITS     3       // rgb lit 1 of 2**bits cycles
`define H4_SYNC_STAGES  2       // button synchronizer flops

`endif

//--- hd44780_pkg.sv
// shared types for the lcd bring-up harness
// lcd data is a fixed 4-bit nibble, R/W is assumed tied low on the board
// rgb fields are plain active-high levels, no current driver behind them
`default_nettype none

package hd44780_pkg;

    // lcd pins as seen by the logic analyzer
    typedef struct packed {
        logic       rs;         // high while the timer sequence runs
        logic       e;          // start or end strobe of the timer
        logic [3:0] data;       // free-running down count
    } lcd_pins_t;

    // rgb alive outputs, active high
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

    // timer exerciser states, one load/wait pair per delay
    typedef enum logic [2:0] {
        idle   = 3'd0,
        load_a = 3'd1,
        wait_a = 3'd2,
        load_b = 3'd3,
        wait_b = 3'd4,
        load_c = 3'd5,
        wait_c = 3'd6,
        lockup = 3'd7          // final state, never left until reset
    } exer_state_t;

endpackage

`default_nettype wire

//--- hd44780_arm.sv
// arms the harness on the first button press
// button is active low and arrives already pulled up, no debounce
// first sampled low arms the design two edges later
// the latch is sticky, only i_rst_n clears it
`timescale 1ns/1ns
`default_nettype none

`include "hd44780_defines.svh"

module hd44780_arm (
    input  wire  clk,
    input  wire  i_rst_n,
    input  wire  i_button_n,       // push button, low when pressed
    output logic o_run_en,         // armed level, releases the run logic
    output logic o_la_strobe       // logic analyzer trigger, stays high
);

    // press shifts in as a one, oldest sample at the top
    logic [`H4_SYNC_STAGES-1:0] sync_q;
    logic                       armed_q;   // set once, held for good

    // ************************************************************************
    // synchronizer and one-time latch
    // ************************************************************************
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q  <= '0;
            armed_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[`H4_SYNC_STAGES-2:0], ~i_button_n};  // invert to active high
            // undebounced on purpose, the first bounce arms it
            if (sync_q[`H4_SYNC_STAGES-1]) begin
                armed_q <= 1'b1;
            end
        end
    end

    assign o_run_en    = armed_q;   // extended reset ends here
    assign o_la_strobe = armed_q;   // analyzer waits for this rising edge

endmodule

`default_nettype wire

//--- hd44780_state_timer.sv
// loadable down-counting delay timer
// a start strobe sampled at edge k with load value N gives one end strobe
// in the cycle after edge k+N+1, so N=0 still takes one tick
// a start while busy reloads the count, no end strobe for the first load
// i_run_en low holds the timer idle, it acts as an extended reset
`timescale 1ns/1ns
`default_nettype none

`include "hd44780_defines.svh"

module hd44780_state_timer (
    input  wire                      clk,
    input  wire                      i_rst_n,
    input  wire                      i_run_en,      // low = held idle
    input  wire                      i_start_stb,   // one cycle, loads the count
    input  wire [`H4_TIMER_BITS-1:0] i_load_val,    // delay in ticks
    output logic                     o_end_stb      // one cycle when done
);

    logic [`H4_TIMER_BITS-1:0] count_q;   // ticks left
    logic                      busy_q;    // a delay is running
    logic                      end_q;

    // ************************************************************************
    // counter and end strobe
    // ************************************************************************
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count_q <= '0;
            busy_q  <= 1'b0;
            end_q   <= 1'b0;
        end else if (!i_run_en) begin
            // not armed yet, keep everything quiet
            count_q <= '0;
            busy_q  <= 1'b0;
            end_q   <= 1'b0;
        end else begin
            end_q <= 1'b0;                      // strobe lasts one cycle
            if (i_start_stb) begin
                count_q <= i_load_val;          // load wins over a running count
                busy_q  <= 1'b1;
            end else if (busy_q) begin
                if (count_q == '0) begin
                    end_q  <= 1'b1;             // fire and go idle
                    busy_q <= 1'b0;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
        end
    end

    assign o_end_stb = end_q;

endmodule

`default_nettype wire

//--- hd44780_timer_exerciser.sv
// runs the state timer through delays A, B and C once, then locks up
// lcd pins are only a window for the logic analyzer, no real lcd protocol
// rs marks the active sequence, e is start or end strobe, data counts down
// e is combinational from registers, so it may glitch on the lcd pin
// the whole block is held in idle until i_run_en goes high
`timescale 1ns/1ns
`default_nettype none

`include "hd44780_defines.svh"

module hd44780_timer_exerciser (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire                     i_run_en,   // armed level from the button
    output hd44780_pkg::lcd_pins_t  o_lcd       // analyzer view of the sequence
);

    hd44780_pkg::exer_state_t  state_q;
    logic                      start_stb;   // registered, one cycle per load state
    logic [`H4_TIMER_BITS-1:0] load_val;    // delay handed to the timer
    logic                      end_stb;     // back from the timer
    logic                      rs_q;
    logic [3:0]                data_q;

    // ************************************************************************
    // sequence FSM
    // ************************************************************************
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q   <= hd44780_pkg::idle;
            start_stb <= 1'b0;
            load_val  <= '0;
            rs_q      <= 1'b0;
            data_q    <= 4'd0;
        end else if (!i_run_en) begin
            // extended reset until the button is pressed
            state_q   <= hd44780_pkg::idle;
            start_stb <= 1'b0;
            rs_q      <= 1'b0;
        end else begin
            data_q    <= data_q - 4'd1;   // just something to watch on the pins
            start_stb <= 1'b0;            // load states override below

            case (state_q)
                hd44780_pkg::idle: begin
                    state_q <= hd44780_pkg::load_a;
                    rs_q    <= 1'b1;      // sequence active from here
                end
                hd44780_pkg::load_a: begin
                    load_val  <= `H4_TIMER_BITS'(`H4_DELAY_A);
                    start_stb <= 1'b1;
                    state_q   <= hd44780_pkg::wait_a;
                end
                hd44780_pkg::wait_a: begin
                    if (end_stb) begin
                        state_q <= hd44780_pkg::load_b;
                    end
                end
                hd44780_pkg::load_b: begin
                    load_val  <= `H4_TIMER_BITS'(`H4_DELAY_B);
                    start_stb <= 1'b1;
                    state_q   <= hd44780_pkg::wait_b;
                end
                hd44780_pkg::wait_b: begin
                    if (end_stb) begin
                        state_q <= hd44780_pkg::load_c;
                    end
                end
                hd44780_pkg::load_c: begin
                    load_val  <= `H4_TIMER_BITS'(`H4_DELAY_C);
                    start_stb <= 1'b1;
                    state_q   <= hd44780_pkg::wait_c;
                end
                hd44780_pkg::wait_c: begin
                    if (end_stb) begin
                        state_q <= hd44780_pkg::lockup;
                        rs_q    <= 1'b0;  // sequence over
                    end
                end
                hd44780_pkg::lockup: begin
                    state_q <= hd44780_pkg::lockup;  // stay, going to idle would loop forever
                end
                default: begin
                    state_q <= hd44780_pkg::idle;
                end
            endcase
        end
    end

    // timer under test, its strobes stay inside this block
    hd44780_state_timer u_timer (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_run_en    (i_run_en),
        .i_start_stb (start_stb),
        .i_load_val  (load_val),
        .o_end_stb   (end_stb)
    );

    // ************************************************************************
    // lcd pin mapping
    // ************************************************************************
    always_comb begin
        o_lcd.rs   = rs_q;
        o_lcd.e    = start_stb | end_stb;   // both edges of every delay visible
        o_lcd.data = data_q;
    end

endmodule

`default_nettype wire

//--- hd44780_alive_leds.sv
// alive indicators driven from one free-running blink counter
// rgb outputs are plain active-high levels, dimmed by a short pwm counter
// external leds are active low (anode to supply) and dark until armed
// outputs are registered, they lag the counters by one cycle
`timescale 1ns/1ns
`default_nettype none

`include "hd44780_defines.svh"

module hd44780_alive_leds (
    input  wire               clk,
    input  wire               i_rst_n,
    input  wire               i_run_en,   // armed, lets the external leds run
    output hd44780_pkg::rgb_t o_rgb,      // onboard rgb, active high
    output logic [3:0]        o_led_n     // external leds, active low
);

    localparam int BB = `H4_BLINK_BITS;   // short alias for the bit picks

    logic [BB-1:0]             blink_q;
    logic [`H4_PWM_BITS-1:0]   pwm_q;
    logic                      pwm_en;    // one cycle in 2**bits
    hd44780_pkg::rgb_t         rgb_q;
    logic [3:0]                led_n_q;

    assign pwm_en = &pwm_q;               // lit only when pwm counter is all ones

    // ************************************************************************
    // counters and registered outputs
    // ************************************************************************
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            blink_q <= '0;
            pwm_q   <= '0;
            rgb_q   <= '0;
            led_n_q <= 4'b1111;                    // dark
        end else begin
            blink_q <= blink_q + 1'b1;
            pwm_q   <= pwm_q + 1'b1;

            // rgb blinks from the top bits whether armed or not
            rgb_q.g <= pwm_en & ~blink_q[BB-1];
            rgb_q.b <= pwm_en &  blink_q[BB-1];
            rgb_q.r <= pwm_en & ~blink_q[BB-2];

            if (i_run_en) begin
                led_n_q[0] <=  blink_q[BB-2];
                led_n_q[1] <= ~blink_q[BB-3];
                led_n_q[2] <=  blink_q[BB-3];
                led_n_q[3] <= ~blink_q[BB-4];
            end else begin
                led_n_q <= 4'b1111;                // not armed, keep them off
            end
        end
    end

    assign o_rgb   = rgb_q;
    assign o_led_n = led_n_q;

endmodule

`default_nettype wire

//--- hd44780_top.sv
// top of the lcd bring-up harness, instances and wires only
// clk comes from outside, no on-chip oscillator or clock divider
// i_button_n must already be pulled up at the pad
// rgb outputs are plain levels, the current driver is outside this design
`timescale 1ns/1ns
`default_nettype none

module hd44780_top (
    input  wire                    clk,
    input  wire                    i_rst_n,       // async, active low
    input  wire                    i_button_n,    // push button, low when pressed
    output hd44780_pkg::lcd_pins_t o_lcd,         // rs, e and data nibble
    output hd44780_pkg::rgb_t      o_rgb,         // onboard rgb alive
    output logic [3:0]             o_led_n,       // external alive leds, active low
    output logic                   o_la_strobe    // logic analyzer trigger
);

    logic run_en;   // armed level, doubles as the end of the extended reset

    // ************************************************************************
    // arming
    // ************************************************************************
    hd44780_arm u_arm (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_button_n  (i_button_n),
        .o_run_en    (run_en),
        .o_la_strobe (o_la_strobe)
    );

    // timer exercise on the lcd pins, timer lives inside
    hd44780_timer_exerciser u_exer (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_run_en (run_en),
        .o_lcd    (o_lcd)
    );

    // ************************************************************************
    // alive leds
    // ************************************************************************
    hd44780_alive_leds u_leds (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_run_en (run_en),
        .o_rgb    (o_rgb),
        .o_led_n  (o_led_n)
    );

endmodule

`default_nettype wire

//--- hd44780_assertions.sv
// concurrent checks on the timer strobes and the exerciser FSM
// bound into hd44780_timer_exerciser, it reads the internal start, end and state
// every check is off while i_rst_n is low
`timescale 1ns/1ns
`default_nettype none

module hd44780_assertions (
    input wire                             clk,
    input wire                             i_rst_n,
    input wire                             start_stb,   // exerciser to timer
    input wire                             end_stb,     // timer back to exerciser
    input wire hd44780_pkg::exer_state_t   state        // exerciser state register
);

    logic pending_q;        // a start was seen, its end is still due
    int   error_count = 0;  // failed checks so far

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pending_q <= 1'b0;
        end else if (start_stb) begin
            pending_q <= 1'b1;
        end else if (end_stb) begin
            pending_q <= 1'b0;           // delay finished
        end
    end

    // ************************************************************************
    // strobe and FSM rules
    // ************************************************************************
    start_one_cycle: assert property (@(posedge clk) disable iff (!i_rst_n)
        start_stb |=> !start_stb)
        else begin
            $error("start strobe high for more than one cycle");
            error_count++;
        end

    end_needs_start: assert property (@(posedge clk) disable iff (!i_rst_n)
        end_stb |-> pending_q)
        else begin
            $error("end strobe without a preceding start strobe");
            error_count++;
        end

    // lockup is final until reset
    lockup_is_final: assert property (@(posedge clk) disable iff (!i_rst_n)
        (state == hd44780_pkg::lockup) |=> (state == hd44780_pkg::lockup))
        else begin
            $error("exerciser left the lockup state");
            error_count++;
        end

endmodule

`default_nettype wire

//--- tb_hd44780_top.sv
// testbench for the lcd bring-up harness
// random button with bounce, fixed seed, checked every cycle against a cycle model
// inputs change 2 ns after the rising edge, outputs are compared at the falling edge
// stops at the first mismatch or timeout
`timescale 1ns/1ns
`default_nettype none

`include "hd44780_defines.svh"

module tb_hd44780_top;

    localparam int BB = `H4_BLINK_BITS;

    logic                   clk;
    logic                   i_rst_n;
    logic                   i_button_n;
    hd44780_pkg::lcd_pins_t o_lcd;
    hd44780_pkg::rgb_t      o_rgb;
    logic [3:0]             o_led_n;
    logic                   o_la_strobe;

    // ************************************************************************
    // reference model state
    // ************************************************************************
    int                      edge_n;        // edges since reset release
    int                      first_low;     // edge of first sampled press, -1 = none yet
    logic                    m_armed;
    int                      run_edges;     // edges that saw run_en high
    logic [BB-1:0]           m_blink;
    logic [`H4_PWM_BITS-1:0] m_pwm;
    hd44780_pkg::lcd_pins_t  m_lcd;
    hd44780_pkg::rgb_t       m_rgb;
    logic [3:0]              m_led_n;
    int                      start_off[3];  // run-edge offsets where start goes high
    int                      end_off[3];
    int                      lock_off;      // rs drops after this run edge

    hd44780_top dut0 (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_button_n  (i_button_n),
        .o_lcd       (o_lcd),
        .o_rgb       (o_rgb),
        .o_led_n     (o_led_n),
        .o_la_strobe (o_la_strobe)
    );

    bind hd44780_timer_exerciser hd44780_assertions u_assert (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .start_stb (start_stb),
        .end_stb   (end_stb),
        .state     (state_q)
    );

    always #20 clk = ~clk;   // 40 ns period

    // where the e pulses fall, counted in run edges from the first armed edge
    task automatic build_schedule;
        int delays[3];
        delays[0] = `H4_DELAY_A;
        delays[1] = `H4_DELAY_B;
        delays[2] = `H4_DELAY_C;
        start_off[0] = 1;                                  // idle -> load_a -> start
        for (int i = 0; i < 3; i++) begin
            end_off[i] = start_off[i] + 1 + delays[i] + 1; // timer samples one edge later
            if (i < 2) begin
                start_off[i+1] = end_off[i] + 2;           // wait sees end, load raises start
            end
        end
        lock_off = end_off[2] + 1;
    endtask

    // advance the model by one rising edge, inputs as the DUT sampled them
    task automatic model_edge;
        logic run_prev;
        int   t;
        logic e_now;
        run_prev = m_armed;
        edge_n++;
        // leds come from the counters before the increment
        if (&m_pwm) begin
            m_rgb.g = ~m_blink[BB-1];
            m_rgb.b =  m_blink[BB-1];
            m_rgb.r = ~m_blink[BB-2];
        end else begin
            m_rgb = '0;
        end
        if (run_prev) begin
            m_led_n = {~m_blink[BB-4], m_blink[BB-3], ~m_blink[BB-3], m_blink[BB-2]};
        end else begin
            m_led_n = 4'b1111;
        end
        m_blink = m_blink + 1'b1;
        m_pwm   = m_pwm + 1'b1;
        // arming, sticky
        if (first_low < 0 && !i_button_n) begin
            first_low = edge_n;
        end
        if (first_low >= 0 && edge_n >= first_low + `H4_SYNC_STAGES) begin
            m_armed = 1'b1;
        end
        // exerciser view on the lcd pins
        if (run_prev) begin
            t = run_edges;
            run_edges++;
            m_lcd.data = m_lcd.data - 4'd1;
            m_lcd.rs   = (t < lock_off);
            e_now = 1'b0;
            for (int i = 0; i < 3; i++) begin
                if (t == start_off[i] || t == end_off[i]) begin
                    e_now = 1'b1;
                end
            end
            m_lcd.e = e_now;
        end
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%02h, expected 0x%02h at %0t ns", name, got, exp, $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_outputs;
        check_value("o_la_strobe", 8'(o_la_strobe), 8'(m_armed));
        check_value("o_lcd.rs", 8'(o_lcd.rs), 8'(m_lcd.rs));
        check_value("o_lcd.e", 8'(o_lcd.e), 8'(m_lcd.e));
        check_value("o_lcd.data", 8'(o_lcd.data), 8'(m_lcd.data));
        check_value("o_rgb", 8'(o_rgb), 8'(m_rgb));
        check_value("o_led_n", 8'(o_led_n), 8'(m_led_n));
        // bound protocol checks on the timer and the exerciser
        assert (dut0.u_exer.u_assert.error_count == 0) else begin
            $display("a protocol assertion on the timer or exerciser failed at %0t ns", $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "protocol assertion");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    endtask

    // one clock: model edge, drive the button, compare at the falling edge
    task automatic step_cycle(input logic btn);
        @(posedge clk);
        model_edge();
        #2;
        i_button_n = btn;
        @(negedge clk);
        check_outputs();
    endtask

    function automatic logic random_level();
        return logic'($urandom % 2);
    endfunction

    // ************************************************************************
    // stimulus
    // ************************************************************************
    initial begin
        int   idle_cycles;
        int   bounce_cycles;
        int   waited;
        logic saw_rs;
        void'($urandom(32'hf376ab9c));
        clk        = 1'b0;
        i_rst_n    = 1'b0;
        i_button_n = 1'b1;                  // released
        edge_n     = 0;
        first_low  = -1;
        m_armed    = 1'b0;
        run_edges  = 0;
        m_blink    = '0;
        m_pwm      = '0;
        m_lcd      = '0;
        m_rgb      = '0;
        m_led_n    = 4'b1111;
        build_schedule();

        repeat (4) @(posedge clk);
        #2;
        check_outputs();                    // reset values
        i_rst_n = 1'b1;

        // quiet time before the press, everything must stay dark
        idle_cycles = 5 + ($urandom % 20);
        repeat (idle_cycles) step_cycle(1'b1);

        // press with bounce, the first sample is a clean low
        bounce_cycles = 3 + ($urandom % 6);
        step_cycle(1'b0);
        repeat (bounce_cycles) step_cycle(random_level());

        waited = 0;
        while (!o_la_strobe) begin
            if (waited >= 8) begin
                report_timeout("the analyzer strobe");
            end else begin
                step_cycle(random_level());
                waited++;
            end
        end

        // timer sequence runs while the button keeps toggling
        waited = 0;
        saw_rs = 1'b0;
        while (!(saw_rs && !o_lcd.rs)) begin
            if (waited >= 400) begin
                report_timeout("the exerciser to reach lockup");
            end else begin
                step_cycle(random_level());
                waited++;
                if (o_lcd.rs) begin
                    saw_rs = 1'b1;
                end
            end
        end

        repeat (64) step_cycle(random_level());   // e must stay low in lockup

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- hd44780_top.f
hd44780_pkg.sv
hd44780_arm.sv
hd44780_state_timer.sv
hd44780_timer_exerciser.sv
hd44780_alive_leds.sv
hd44780_top.sv
hd44780_assertions.sv
tb_hd44780_top.sv
+incdir+.
